// ==== text_video_top.f ====
vgen_pkg.sv
vgen_cfg_if.sv
vgen_scan_if.sv
video_timing.sv
vgen_regs.sv
text_pixel_gen.sv
dp_ram.sv
text_video_top.sv
text_video_asserts.sv
tb_text_video.sv

// ==== tb_text_video.sv ====
// directed testbench for text_video_top in a 64x16 mode, 88 clocks x 23 lines
// memories get xorshift contents, and pixels are predicted by counting de_o cycles
// inputs change 1 ns after the rising edge, outputs are sampled on the falling edge
`timescale 1ns/1ps

module tb_text_video;

    localparam bit HSYNC_POL  = 1'b0;
    localparam bit VSYNC_POL  = 1'b0;
    localparam int H_VIS      = 64;
    localparam int V_VIS      = 16;
    localparam int LINE_CLKS  = 88;
    localparam int FRAME_CLKS = 2024;

    logic                         clk = 1'b0;
    logic                         reset_i, reg_wr_i, vram_wr_i, font_wr_i, enable_i;
    vgen_pkg::reg_num_t           reg_num_i;
    vgen_pkg::reg_word_t          reg_data_i, reg_data_o;
    logic [9:0]                   vram_waddr_i;
    vgen_pkg::vram_word_t         vram_wdata_i;
    logic [vgen_pkg::FONT_AW-1:0] font_waddr_i;
    vgen_pkg::font_byte_t         font_wdata_i;
    vgen_pkg::pal_idx_t           pal_index_o;
    logic                         hsync_o, vsync_o, de_o;

    vgen_pkg::vram_word_t vram_ref [1024];           // reference copy of vram
    vgen_pkg::font_byte_t font_ref [8192];           // reference copy of font ram
    logic [31:0]          rng_state = 32'h4bc6761f;

    text_video_top #(
        .H_VISIBLE (H_VIS), .H_FRONT (4), .H_SYNC (8), .H_BACK (12),
        .V_VISIBLE (V_VIS), .V_FRONT (2), .V_SYNC (2), .V_BACK (3),
        .HSYNC_POL (HSYNC_POL), .VSYNC_POL (VSYNC_POL), .VRAM_AW (10)
    ) dut (
        .clk (clk), .reset_i (reset_i),
        .reg_wr_i (reg_wr_i), .reg_num_i (reg_num_i),
        .reg_data_i (reg_data_i), .reg_data_o (reg_data_o),
        .vram_wr_i (vram_wr_i), .vram_waddr_i (vram_waddr_i), .vram_wdata_i (vram_wdata_i),
        .font_wr_i (font_wr_i), .font_waddr_i (font_waddr_i), .font_wdata_i (font_wdata_i),
        .enable_i (enable_i), .pal_index_o (pal_index_o),
        .hsync_o (hsync_o), .vsync_o (vsync_o), .de_o (de_o)
    );

    always #4 clk = ~clk;                            // 8 ns period

    initial begin
        #(16 * FRAME_CLKS * 8);                      // 16 frames of the small mode
        $display("watchdog expired before the tests completed");
        $display("=== FAIL ===");
        $fatal(1, "timeout");
    end

    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    // the bound checker counts its failed assertions
    initial begin
        wait (dut.u_asserts.fail_count != 0);
        $display("a bound assertion failed at %0t", $time);
        abort_run();
    end

    task automatic check_pix(string name, vgen_pkg::pal_idx_t got, vgen_pkg::pal_idx_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s = %0h, expected %0h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_reg(string name, vgen_pkg::reg_word_t got, vgen_pkg::reg_word_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s = %0h, expected %0h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_count(string name, int unsigned got, int unsigned exp);
        if (got != exp) begin
            $display("Fail at %0t: %s = %0d, expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // expected pixel from the text rules, independent of pipeline depth
    function automatic vgen_pkg::pal_idx_t predict_pix(int x, int y, int start, int width,
                                                       int height, int bank, int scroll);
        int                           line;
        int                           addr;
        vgen_pkg::vram_word_t         w;
        logic [vgen_pkg::FONT_AW-1:0] fa;
        vgen_pkg::font_byte_t         g;
        line = y + scroll;
        addr = (start + (line / (height + 1)) * width + x / 8) % 1024;  // wraps like VRAM_AW
        w    = vram_ref[addr];
        fa   = {bank[0], w.code, 4'(line % (height + 1))};
        g    = font_ref[fa];
        return g[7 - (x % 8)] ? w.fg : w.bg;
    endfunction

    task automatic write_reg(vgen_pkg::reg_num_t num, vgen_pkg::reg_word_t data);
        @(posedge clk);
        #1;
        reg_wr_i   = 1'b1;
        reg_num_i  = num;
        reg_data_i = data;
        @(posedge clk);
        #1;
        reg_wr_i   = 1'b0;
    endtask

    task automatic read_reg(vgen_pkg::reg_num_t num, output vgen_pkg::reg_word_t data);
        @(posedge clk);
        #1;
        reg_num_i = num;
        @(posedge clk);
        #1;
        data = reg_data_o;                           // one clock of read latency
    endtask

    task automatic load_memories();
        for (int a = 0; a < 1024 + 8192; a++) begin
            rng_state = xorshift32(rng_state);
            @(posedge clk);
            #1;
            vram_wr_i = (a < 1024);
            font_wr_i = (a >= 1024);
            if (a < 1024) begin
                vram_ref[a]  = rng_state[15:0];
                vram_waddr_i = 10'(a);
                vram_wdata_i = rng_state[15:0];
            end else begin
                font_ref[a - 1024] = rng_state[23:16];
                font_waddr_i       = 13'(a - 1024);
                font_wdata_i       = rng_state[23:16];
            end
        end
        @(posedge clk);
        #1;
        vram_wr_i = 1'b0;
        font_wr_i = 1'b0;
    endtask

    task automatic wait_vsync_active();
        do @(negedge clk); while (vsync_o != VSYNC_POL);
    endtask

    // returns on the first clock after vsync, which opens the back porch
    task automatic wait_frame_start();
        wait_vsync_active();
        do @(negedge clk); while (vsync_o == VSYNC_POL);
    endtask

    task automatic watch_blank_frame();
        int unsigned de_cnt = 0;
        repeat (FRAME_CLKS) begin
            @(negedge clk);
            if (de_o) de_cnt++;
            check_pix("pal_index_o", pal_index_o, '0);
        end
        check_count("de_o high clocks per frame", de_cnt, 0);
    endtask

    task automatic check_frame(int start, int width, int height, int bank, int scroll);
        for (int n = 0; n < H_VIS * V_VIS; n++) begin
            do @(negedge clk); while (!de_o);
            check_pix("pal_index_o", pal_index_o,
                      predict_pix(n % H_VIS, n / H_VIS, start, width, height, bank, scroll));
        end
    endtask

    task automatic measure_sync_geometry();
        int unsigned h_len = 0, h_start = 0, h_pulses = 0;
        int unsigned de_len = 0, de_runs = 0, v_clks = 0;
        bit          h_prev, de_prev, h_seen = 1'b0, de_seen = 1'b0, h_act;
        h_prev  = (hsync_o == HSYNC_POL);
        de_prev = de_o;
        for (int unsigned cyc = 0; cyc < FRAME_CLKS; cyc++) begin
            @(negedge clk);
            h_act = (hsync_o == HSYNC_POL);
            if (h_act && !h_prev) begin              // pulse start
                if (h_seen) check_count("hsync_o period", cyc - h_start, LINE_CLKS);
                h_start = cyc;
                h_seen  = 1'b1;
                h_len   = 0;
                h_pulses++;
            end
            if (h_act) h_len++;
            if (!h_act && h_prev && h_seen) check_count("hsync_o pulse length", h_len, 8);
            if (de_o && !de_prev) begin
                de_seen = 1'b1;
                de_len  = 0;
            end
            if (de_o) de_len++;
            if (!de_o && de_prev && de_seen) begin
                check_count("de_o run length", de_len, H_VIS);
                de_runs++;
            end
            if (vsync_o == VSYNC_POL) v_clks++;
            h_prev  = h_act;
            de_prev = de_o;
        end
        check_count("hsync_o pulses per frame", h_pulses, FRAME_CLKS / LINE_CLKS);
        check_count("de_o runs per frame", de_runs, V_VIS);
        check_count("vsync_o active clocks", v_clks, 2 * LINE_CLKS);
    endtask

    task automatic test_reset_readback();
        vgen_pkg::reg_word_t d;
        read_reg(3'd0, d);
        check_reg("reg_data_o width", d, 16'd64);
        read_reg(3'd1, d);
        check_reg("reg_data_o height", d, 16'd16);
        read_reg(3'd2, d);
        check_reg("reg_data_o feature", d, 16'h8001);
        watch_blank_frame();
    endtask

    task automatic test_status();
        vgen_pkg::reg_word_t st;
        wait_vsync_active();
        read_reg(3'd3, st);
        check_reg("status vblank flag", st & 16'h8000, 16'h8000);
        if (st[10:0] < 11'd18) begin
            $display("status line count %0d is below 18 during vsync", st[10:0]);
            abort_run();
        end
        do @(negedge clk); while (!de_o);
        read_reg(3'd3, st);
        check_reg("status visible flags", st & 16'hc000, 16'h0000);
    endtask

    task automatic test_configuration();
        wait_vsync_active();                         // vertical blank
        write_reg(vgen_pkg::REG_DISPSTART, 16'd40);
        write_reg(vgen_pkg::REG_LINEWIDTH, 16'd12);
        write_reg(vgen_pkg::REG_FONTCTRL, 16'h0107); // bank 1, 8 rows
        write_reg(vgen_pkg::REG_SCROLLY, 16'd3);
        wait_frame_start();
        wait_frame_start();                          // skip one frame
        check_frame(40, 12, 7, 1, 3);
    endtask

    task automatic test_disable();
        @(posedge clk);
        #1;
        enable_i = 1'b0;
        wait_frame_start();
        watch_blank_frame();
    endtask

    initial begin
        reset_i      = 1'b1;
        reg_wr_i     = 1'b0;
        reg_num_i    = '0;
        reg_data_i   = '0;
        vram_wr_i    = 1'b0;
        vram_waddr_i = '0;
        vram_wdata_i = '0;
        font_wr_i    = 1'b0;
        font_waddr_i = '0;
        font_wdata_i = '0;
        enable_i     = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        reset_i = 1'b0;
        fork                                          // display is off while loading
            load_memories();
            test_reset_readback();
        join
        enable_i = 1'b1;
        wait_frame_start();
        fork
            measure_sync_geometry();
            check_frame(0, H_VIS / 8, 15, 0, 0);
        join
        test_status();
        test_configuration();
        test_disable();
        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== text_video_asserts.sv ====
// concurrent checks on the text video outputs, bound into text_video_top
// the scan visible flags are taken from the scan interface inside the top level
`timescale 1ns/1ps

module text_video_asserts #(
    parameter bit HSYNC_POL = 1'b0
) (
    input logic               clk,
    input logic               reset_i,
    input logic               de_i,
    input logic               hsync_i,
    input vgen_pkg::pal_idx_t pal_index_i,
    input logic               vram_rd_i,
    input logic               h_visible_i,
    input logic               v_visible_i
);

    int unsigned fail_count = 0;                            // failed assertions so far

    a_de_outside_hsync : assert property (@(posedge clk) disable iff (reset_i)
        !(de_i && (hsync_i == HSYNC_POL)))                  // no active video inside sync
        else begin
            fail_count++;
            $error("de_o high while hsync_o is active");
        end

    a_blank_index_zero : assert property (@(posedge clk) disable iff (reset_i)
        !de_i |-> (pal_index_i == '0))
        else begin
            fail_count++;
            $error("pal_index_o not zero while de_o is low");
        end

    // a read leads the visible pixels of a visible line by FETCH_LEAD clocks at most
    a_fetch_in_window : assert property (@(posedge clk) disable iff (reset_i)
        $past(vram_rd_i, vgen_pkg::FETCH_LEAD) |->
            $past(v_visible_i, vgen_pkg::FETCH_LEAD)
            && (h_visible_i || $past(h_visible_i, vgen_pkg::FETCH_LEAD)))
        else begin
            fail_count++;
            $error("vram read outside the fetch window");
        end

endmodule

bind text_video_top text_video_asserts #(.HSYNC_POL (HSYNC_POL)) u_asserts (
    .clk         (clk),
    .reset_i     (reset_i),
    .de_i        (de_o),
    .hsync_i     (hsync_o),
    .pal_index_i (pal_index_o),
    .vram_rd_i   (vram_rd),
    .h_visible_i (scan_bus.h_visible),
    .v_visible_i (scan_bus.v_visible)
);

// ==== text_video_top.sv ====
// text-mode video generator top level
// vram and font ram are loaded through their own write ports and read only by video
// no back-pressure anywhere, and all strobes are one clock wide
// defaults give 640x480 with negative sync pulses
`timescale 1ns/1ps

module text_video_top #(
    parameter int H_VISIBLE = 640,
    parameter int H_FRONT   = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BACK    = 48,
    parameter int V_VISIBLE = 480,
    parameter int V_FRONT   = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 33,
    parameter bit HSYNC_POL = 1'b0,
    parameter bit VSYNC_POL = 1'b0,
    parameter int VRAM_AW   = 16
) (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          reg_wr_i,
    input  vgen_pkg::reg_num_t            reg_num_i,
    input  vgen_pkg::reg_word_t           reg_data_i,
    output vgen_pkg::reg_word_t           reg_data_o,
    input  logic                          vram_wr_i,
    input  logic [VRAM_AW-1:0]            vram_waddr_i,
    input  vgen_pkg::vram_word_t          vram_wdata_i,
    input  logic                          font_wr_i,
    input  logic [vgen_pkg::FONT_AW-1:0]  font_waddr_i,
    input  vgen_pkg::font_byte_t          font_wdata_i,
    input  logic                          enable_i,
    output vgen_pkg::pal_idx_t            pal_index_o,
    output logic                          hsync_o,
    output logic                          vsync_o,
    output logic                          de_o
);

    logic                          vram_rd;
    logic [VRAM_AW-1:0]            vram_raddr;
    vgen_pkg::vram_word_t          vram_rdata;
    logic                          font_rd;
    logic [vgen_pkg::FONT_AW-1:0]  font_raddr;
    vgen_pkg::font_byte_t          font_rdata;

    vgen_cfg_if  cfg_bus ();
    vgen_scan_if scan_bus ();

    video_timing #(
        .H_VISIBLE (H_VISIBLE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
        .V_VISIBLE (V_VISIBLE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK),
        .HSYNC_POL (HSYNC_POL), .VSYNC_POL (VSYNC_POL)
    ) u_timing (
        .clk (clk), .reset_i (reset_i), .scan (scan_bus.gen)
    );

    vgen_regs #(.H_VISIBLE (H_VISIBLE), .V_VISIBLE (V_VISIBLE)) u_regs (
        .clk        (clk),
        .reset_i    (reset_i),
        .reg_wr_i   (reg_wr_i),
        .reg_num_i  (reg_num_i),
        .reg_data_i (reg_data_i),
        .reg_data_o (reg_data_o),
        .cfg        (cfg_bus.src),
        .scan       (scan_bus.stat)
    );

    text_pixel_gen #(.VRAM_AW (VRAM_AW)) u_pixel (
        .clk          (clk),
        .reset_i      (reset_i),
        .enable_i     (enable_i),
        .cfg          (cfg_bus.dst),
        .scan         (scan_bus.pix),
        .vram_rd_o    (vram_rd),
        .vram_raddr_o (vram_raddr),
        .vram_rdata_i (vram_rdata),
        .font_rd_o    (font_rd),
        .font_raddr_o (font_raddr),
        .font_rdata_i (font_rdata),
        .pal_index_o  (pal_index_o),
        .hsync_o      (hsync_o),
        .vsync_o      (vsync_o),
        .de_o         (de_o)
    );

    dp_ram #(.word_t (vgen_pkg::vram_word_t), .AW (VRAM_AW)) u_vram (
        .clk (clk), .wr_i (vram_wr_i), .waddr_i (vram_waddr_i), .wdata_i (vram_wdata_i),
        .rd_i (vram_rd), .raddr_i (vram_raddr), .rdata_o (vram_rdata)
    );

    dp_ram #(.word_t (vgen_pkg::font_byte_t), .AW (vgen_pkg::FONT_AW)) u_font (
        .clk (clk), .wr_i (font_wr_i), .waddr_i (font_waddr_i), .wdata_i (font_wdata_i),
        .rd_i (font_rd), .raddr_i (font_raddr), .rdata_o (font_rdata)
    );

endmodule

// ==== dp_ram.sv ====
// single-clock RAM, one write port and one registered read port
// the read output holds until the next rd_i
// a read of the address being written returns the old word
`timescale 1ns/1ps

module dp_ram #(
    parameter type word_t = logic [7:0],
    parameter int  AW     = 8
) (
    input  logic          clk,
    input  logic          wr_i,
    input  logic [AW-1:0] waddr_i,
    input  word_t         wdata_i,
    input  logic          rd_i,
    input  logic [AW-1:0] raddr_i,
    output word_t         rdata_o
);

    word_t mem [2**AW];                 // no reset, contents loaded through the write port

    always_ff @(posedge clk) begin
        if (wr_i) begin
            mem[waddr_i] <= wdata_i;
        end
        if (rd_i) begin
            rdata_o <= mem[raddr_i];
        end
    end

endmodule

// ==== text_pixel_gen.sv ====
// text pipeline: vram word, then glyph row, then an 8-pixel shifter
// the first cell is fetched FETCH_LEAD clocks before the visible region,
// so the shifter holds pixel 0 exactly when the scan turns visible
// outputs lag the scan by one clock; sync, enable and pixel stay aligned
// start address, scroll and enable only change at frame end
`timescale 1ns/1ps

module text_pixel_gen #(
    parameter int VRAM_AW = 16
) (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          enable_i,
    vgen_cfg_if.dst                       cfg,
    vgen_scan_if.pix                      scan,
    output logic                          vram_rd_o,
    output logic [VRAM_AW-1:0]            vram_raddr_o,
    input  vgen_pkg::vram_word_t          vram_rdata_i,
    output logic                          font_rd_o,
    output logic [vgen_pkg::FONT_AW-1:0]  font_raddr_o,
    input  vgen_pkg::font_byte_t          font_rdata_i,
    output vgen_pkg::pal_idx_t            pal_index_o,
    output logic                          hsync_o,
    output logic                          vsync_o,
    output logic                          de_o
);

    logic                                  tg_enable;      // text generation on for this frame
    logic [$clog2(vgen_pkg::CHAR_W)-1:0]   char_x;         // phase within a cell
    logic [VRAM_AW-1:0]                    text_addr;      // next word to fetch
    logic [VRAM_AW-1:0]                    line_addr;      // first word of current text row
    logic [VRAM_AW-1:0]                    next_line;
    logic [3:0]                            glyph_row;
    logic                                  fetch_q;        // vram data valid this clock
    vgen_pkg::vram_word_t                  attr_q;         // word whose glyph is in flight
    vgen_pkg::vram_word_t                  color_q;        // word of the cell being shifted
    vgen_pkg::font_byte_t                  shifter;        // bit 7 is current pixel
    logic                                  de_next;

    assign next_line    = line_addr + cfg.line_width[VRAM_AW-1:0];
    assign de_next      = tg_enable && scan.h_visible && scan.v_visible;

    // one vram read per cell, then the glyph row on the following clock
    assign vram_rd_o    = tg_enable && scan.fetch_win && (char_x == '0);
    assign vram_raddr_o = text_addr;
    assign font_rd_o    = fetch_q;
    assign font_raddr_o = {cfg.font_bank, vram_rdata_i.code, glyph_row};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            tg_enable   <= 1'b0;
            char_x      <= '0;
            fetch_q     <= 1'b0;
            text_addr   <= '0;
            line_addr   <= '0;
            glyph_row   <= '0;
            de_o        <= 1'b0;
            pal_index_o <= '0;
        end else begin
            fetch_q <= vram_rd_o;
            char_x  <= scan.fetch_win ? char_x + 1'b1 : '0;    // phase 0 at window start
            if (vram_rd_o) begin
                text_addr <= text_addr + 1'b1;
            end
            if (scan.frame_end) begin
                tg_enable <= enable_i;
                text_addr <= cfg.text_start[VRAM_AW-1:0];
                line_addr <= cfg.text_start[VRAM_AW-1:0];
                glyph_row <= cfg.fine_scrolly;
            end else if (scan.line_end) begin
                if (glyph_row == cfg.font_height) begin        // last glyph row, next text row
                    glyph_row <= '0;
                    line_addr <= next_line;
                    text_addr <= next_line;
                end else begin
                    glyph_row <= glyph_row + 1'b1;
                    text_addr <= line_addr;                    // same text row again
                end
            end
            de_o        <= de_next;
            pal_index_o <= !de_next ? '0 : (shifter[7] ? color_q.fg : color_q.bg);
        end
    end

    // glyph and attribute path
    always_ff @(posedge clk) begin
        hsync_o <= scan.hsync;                          // reset scan state is inactive sync
        vsync_o <= scan.vsync;
        if (fetch_q) begin
            attr_q  <= vram_rdata_i;                    // word of the cell just fetched
            color_q <= attr_q;                          // font data here is still the prior cell
            shifter <= font_rdata_i;
        end else begin
            shifter <= {shifter[6:0], 1'b0};
        end
    end

endmodule

// ==== vgen_regs.sv ====
// configuration registers with registered read-back
// a write lands on the clock edge that samples reg_wr_i
// reg_data_o follows reg_num_i one clock later, and register 3 returns live scan status
`timescale 1ns/1ps

module vgen_regs #(
    parameter int H_VISIBLE = 640,
    parameter int V_VISIBLE = 480
) (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                reg_wr_i,
    input  vgen_pkg::reg_num_t  reg_num_i,
    input  vgen_pkg::reg_word_t reg_data_i,
    output vgen_pkg::reg_word_t reg_data_o,
    vgen_cfg_if.src             cfg,
    vgen_scan_if.stat           scan
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cfg.text_start   <= '0;
            cfg.line_width   <= vgen_pkg::reg_word_t'(H_VISIBLE / vgen_pkg::CHAR_W);
            cfg.fine_scrolly <= '0;
            cfg.font_height  <= 4'd15;                  // 8x16 font
            cfg.font_bank    <= 1'b0;
        end else if (reg_wr_i) begin
            case (reg_num_i)
                vgen_pkg::REG_DISPSTART: cfg.text_start   <= reg_data_i;
                vgen_pkg::REG_LINEWIDTH: cfg.line_width   <= reg_data_i;
                vgen_pkg::REG_SCROLLY:   cfg.fine_scrolly <= reg_data_i[3:0];
                vgen_pkg::REG_FONTCTRL: begin
                    cfg.font_height <= reg_data_i[3:0];
                    cfg.font_bank   <= reg_data_i[8];
                end
                default: ;                              // 4..7 not writable
            endcase
        end
    end

    // read mux, low two bits only
    always_ff @(posedge clk) begin
        case (reg_num_i[1:0])
            2'd0:    reg_data_o <= vgen_pkg::reg_word_t'(H_VISIBLE);
            2'd1:    reg_data_o <= vgen_pkg::reg_word_t'(V_VISIBLE);
            2'd2:    reg_data_o <= vgen_pkg::FEATURE_WORD;
            default: reg_data_o <= {~scan.v_visible, ~scan.h_visible, 3'b000, scan.v_count};
        endcase
    end

endmodule

// ==== video_timing.sv ====
// horizontal and vertical scan generator, one pixel per clock
// a line is front porch, sync, back porch, then visible pixels
// a frame is visible lines first, then front porch, sync and back porch
// H_BACK must be at least FETCH_LEAD for the fetch window to fit
`timescale 1ns/1ps

module video_timing #(
    parameter int H_VISIBLE = 640,
    parameter int H_FRONT   = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BACK    = 48,
    parameter int V_VISIBLE = 480,
    parameter int V_FRONT   = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 33,
    parameter bit HSYNC_POL = 1'b0,
    parameter bit VSYNC_POL = 1'b0
) (
    input  logic      clk,
    input  logic      reset_i,
    vgen_scan_if.gen  scan
);

    localparam int W       = vgen_pkg::CNT_W;
    localparam int H_OFF   = H_FRONT + H_SYNC + H_BACK;         // blank clocks before visible
    localparam int H_TOTAL = H_OFF + H_VISIBLE;
    localparam int V_TOTAL = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;

    vgen_pkg::scan_state_e h_state, v_state;
    logic [W-1:0]          h_count, v_count;
    logic [W-1:0]          h_bound, v_bound;                    // last count of current state
    logic                  h_last, v_last;

    // compare-to-boundary: each state ends at a fixed count
    always_comb begin
        case (h_state)
            vgen_pkg::PRE_SYNC:  h_bound = W'(H_FRONT - 1);
            vgen_pkg::SYNC:      h_bound = W'(H_FRONT + H_SYNC - 1);
            vgen_pkg::POST_SYNC: h_bound = W'(H_OFF - 1);
            default:             h_bound = W'(H_TOTAL - 1);
        endcase
        case (v_state)
            vgen_pkg::VISIBLE:   v_bound = W'(V_VISIBLE - 1);
            vgen_pkg::PRE_SYNC:  v_bound = W'(V_VISIBLE + V_FRONT - 1);
            vgen_pkg::SYNC:      v_bound = W'(V_VISIBLE + V_FRONT + V_SYNC - 1);
            default:             v_bound = W'(V_TOTAL - 1);
        endcase
    end

    assign h_last = (h_state == vgen_pkg::VISIBLE) && (h_count == h_bound);
    assign v_last = (v_state == vgen_pkg::POST_SYNC) && (v_count == v_bound);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_state <= vgen_pkg::PRE_SYNC;
            v_state <= vgen_pkg::VISIBLE;                       // frame starts on visible line 0
            h_count <= '0;
            v_count <= '0;
        end else begin
            h_count <= h_last ? '0 : h_count + 1'b1;
            if (h_count == h_bound) begin
                h_state <= vgen_pkg::scan_state_e'(h_state + 2'd1);     // wraps to PRE_SYNC
            end
            if (h_last) begin
                v_count <= v_last ? '0 : v_count + 1'b1;
                if (v_count == v_bound) begin
                    v_state <= vgen_pkg::scan_state_e'(v_state + 2'd1);
                end
            end
        end
    end

    assign scan.h_visible = (h_state == vgen_pkg::VISIBLE);
    assign scan.v_visible = (v_state == vgen_pkg::VISIBLE);
    assign scan.hsync     = (h_state == vgen_pkg::SYNC) ? HSYNC_POL : ~HSYNC_POL;
    assign scan.vsync     = (v_state == vgen_pkg::SYNC) ? VSYNC_POL : ~VSYNC_POL;
    assign scan.fetch_win = scan.v_visible && (h_count >= W'(H_OFF - vgen_pkg::FETCH_LEAD));
    assign scan.line_end  = h_last;
    assign scan.frame_end = h_last && v_last;                   // last pixel of the frame
    assign scan.v_count   = v_count;

endmodule

// ==== vgen_scan_if.sv ====
// scan position and events from the timing generator
// hsync and vsync already carry their output polarity
// line_end and frame_end are one-clock strobes on the last pixel
`timescale 1ns/1ps

interface vgen_scan_if;

    logic                       h_visible;
    logic                       v_visible;
    logic                       hsync;
    logic                       vsync;
    logic                       fetch_win;      // memory fetch window, visible lines only
    logic                       line_end;
    logic                       frame_end;
    logic [vgen_pkg::CNT_W-1:0] v_count;        // current line, 0 = first visible

    modport gen  (output h_visible, v_visible, hsync, vsync, fetch_win,
                         line_end, frame_end, v_count);
    modport pix  (input  h_visible, v_visible, hsync, vsync, fetch_win,
                         line_end, frame_end);
    modport stat (input  h_visible, v_visible, v_count);

endinterface

// ==== vgen_cfg_if.sv ====
// live text configuration from the register block to the pixel generator
// text_start and fine_scrolly are only sampled by the consumer at frame end
`timescale 1ns/1ps

interface vgen_cfg_if;

    vgen_pkg::reg_word_t text_start;            // word address of first cell
    vgen_pkg::reg_word_t line_width;            // words per text row
    logic [3:0]          font_height;           // glyph rows minus one
    logic                font_bank;
    logic [3:0]          fine_scrolly;          // first glyph row of the frame

    modport src (output text_start, line_width, font_height, font_bank, fine_scrolly);
    modport dst (input  text_start, line_width, font_height, font_bank, fine_scrolly);

endinterface

// ==== vgen_pkg.sv ====
// shared types and constants for the text-mode video generator
// scan counters are 11 bits, so a line or a frame is limited to 2047 clocks or lines
// register numbers are 3 bits wide, and read-back decodes only the low two bits
package vgen_pkg;

    localparam int CNT_W      = 11;             // h/v scan counter width
    localparam int CHAR_W     = 8;              // pixels per character cell
    localparam int FETCH_LEAD = CHAR_W + 2;     // one cell plus vram and font latency
    localparam int FONT_AW    = 13;             // {bank, code[7:0], row[3:0]}

    typedef logic [3:0]  pal_idx_t;             // palette index
    typedef logic [7:0]  font_byte_t;           // one glyph row, bit 7 leftmost
    typedef logic [15:0] reg_word_t;
    typedef logic [2:0]  reg_num_t;

    // video ram word: background, foreground, character code
    typedef struct packed {
        pal_idx_t   bg;                         // bits 15:12
        pal_idx_t   fg;                         // bits 11:8
        logic [7:0] code;                       // bits 7:0
    } vram_word_t;

    // write registers
    localparam reg_num_t REG_DISPSTART = 3'd0;  // text start word address
    localparam reg_num_t REG_LINEWIDTH = 3'd1;  // words per text row
    localparam reg_num_t REG_SCROLLY   = 3'd2;  // [3:0] first glyph row of frame
    localparam reg_num_t REG_FONTCTRL  = 3'd3;  // [3:0] height-1, [8] bank

    localparam reg_word_t FEATURE_WORD = 16'h8001;

    // scan phase order, for both the horizontal and vertical counters
    typedef enum logic [1:0] {
        PRE_SYNC  = 2'd0,                       // front porch
        SYNC      = 2'd1,
        POST_SYNC = 2'd2,                       // back porch
        VISIBLE   = 2'd3
    } scan_state_e;

endpackage
